// File: hw/sm_ctrl_pkg.sv
package sm_ctrl_pkg;

    // one memory word or byte address
    typedef logic [15:0] word_t;

    typedef enum logic [1:0]
    {
        CMD_ID      = 2'd0,
        CMD_ID_PREV = 2'd1,
        CMD_DISABLE = 2'd2
    } cmd_op_e;

    // protection unit request codes
    typedef enum logic [2:0]
    {
        REQ_NONE     = 3'd0,
        REQ_PUBSTART = 3'd1,
        REQ_PUBEND   = 3'd2,
        REQ_SECSTART = 3'd3,
        REQ_SECEND   = 3'd4,
        REQ_ID       = 3'd5
    } sm_req_e;

    typedef struct packed
    {
        cmd_op_e op;
        word_t   pc;
        word_t   r15;
        word_t   prev_id;
    } cmd_t;

    // stage 1 to stage 2
    typedef struct packed
    {
        cmd_op_e op;
        logic    sm_valid;
        word_t   r15;
        word_t   prev_id;
    } lookup_job_t;

    // limit is exclusive
    typedef struct packed
    {
        word_t base;
        word_t limit;
    } range_t;

    typedef struct packed
    {
        word_t dest_mask;
        word_t data;
    } reg_wb_t;

    // stage 2 to stage 3
    typedef struct packed
    {
        logic    clear;
        range_t  code;
        range_t  data;
        reg_wb_t wb;
    } sweep_job_t;

    // write-back destinations, one bit per register
    parameter word_t DEST_R15  = 16'h8000;
    parameter word_t DEST_PC   = 16'h0001;
    parameter word_t FAIL_DATA = 16'h0000;

    // byte address step between words
    parameter word_t WORD_BYTES = 16'd2;

endpackage

// File: hw/sm_cmd_intake.sv
`timescale 1ns/1ps

module sm_cmd_intake
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_req,
    input  sm_ctrl_pkg::cmd_t        cmd,
    input  logic                     sm_select_valid,
    input  logic                     lookup_ack,
    output logic                     cmd_ack,
    output sm_ctrl_pkg::word_t       sm_select,
    output logic                     lookup_req,
    output sm_ctrl_pkg::lookup_job_t lookup_job
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_VALID,
        S_REQ,
        S_REL
    } state_t;

    state_t            state;
    sm_ctrl_pkg::cmd_t cmd_q;
    logic              sm_valid_q;

    // ID looks up the module holding r15, DISABLE the one holding pc
    assign sm_select = (cmd_q.op == sm_ctrl_pkg::CMD_ID) ? cmd_q.r15 : cmd_q.pc;

    assign lookup_job.op       = cmd_q.op;
    assign lookup_job.sm_valid = sm_valid_q;
    assign lookup_job.r15      = cmd_q.r15;
    assign lookup_job.prev_id  = cmd_q.prev_id;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_IDLE;
            cmd_ack    <= 1'b0;
            lookup_req <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (cmd_req)
                        state <= S_VALID;
                end
                S_VALID:
                begin
                    lookup_req <= 1'b1;
                    state      <= S_REQ;
                end
                S_REQ:
                begin
                    // stage 2 is done with sm_select once it acks
                    if (lookup_ack)
                    begin
                        lookup_req <= 1'b0;
                        cmd_ack    <= 1'b1;
                        state      <= S_REL;
                    end
                end
                S_REL:
                begin
                    if (!cmd_req && !lookup_ack)
                    begin
                        cmd_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && cmd_req)
            cmd_q <= cmd;
        // ID_PREV needs no module, always valid
        if (state == S_VALID)
            sm_valid_q <= (cmd_q.op == sm_ctrl_pkg::CMD_ID_PREV) || sm_select_valid;
    end

endmodule

// File: hw/sm_range_lookup.sv
`timescale 1ns/1ps

module sm_range_lookup
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     lookup_req,
    input  sm_ctrl_pkg::lookup_job_t lookup_job,
    input  sm_ctrl_pkg::word_t       sm_data,
    input  logic                     sweep_ack,
    output logic                     lookup_ack,
    output sm_ctrl_pkg::sm_req_e     sm_req,
    output logic                     sweep_req,
    output sm_ctrl_pkg::sweep_job_t  sweep_job
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_PS,
        S_PE,
        S_SS,
        S_SE,
        S_ID,
        S_SWEEP,
        S_HOLD
    } state_t;

    state_t                  state;
    sm_ctrl_pkg::sweep_job_t job_q;
    sm_ctrl_pkg::reg_wb_t    wb_init;
    logic                    accept;
    logic                    do_disable;
    logic                    do_id;

    assign accept     = (state == S_IDLE) && lookup_req;
    assign do_disable = lookup_job.sm_valid && (lookup_job.op == sm_ctrl_pkg::CMD_DISABLE);
    assign do_id      = lookup_job.sm_valid && (lookup_job.op == sm_ctrl_pkg::CMD_ID);
    assign sweep_job  = job_q;

    always_comb
    begin
        case (state)
            S_PS:    sm_req = sm_ctrl_pkg::REQ_PUBSTART;
            S_PE:    sm_req = sm_ctrl_pkg::REQ_PUBEND;
            S_SS:    sm_req = sm_ctrl_pkg::REQ_SECSTART;
            S_SE:    sm_req = sm_ctrl_pkg::REQ_SECEND;
            S_ID:    sm_req = sm_ctrl_pkg::REQ_ID;
            default: sm_req = sm_ctrl_pkg::REQ_NONE;
        endcase
    end

    // result as known at accept time, ID data arrives later
    always_comb
    begin
        wb_init.dest_mask = sm_ctrl_pkg::DEST_R15;
        wb_init.data      = sm_ctrl_pkg::FAIL_DATA;
        if (lookup_job.sm_valid)
        begin
            case (lookup_job.op)
                sm_ctrl_pkg::CMD_ID_PREV:
                    wb_init.data = lookup_job.prev_id;
                sm_ctrl_pkg::CMD_DISABLE:
                begin
                    wb_init.dest_mask = sm_ctrl_pkg::DEST_PC;
                    wb_init.data      = lookup_job.r15;
                end
                default:
                    wb_init.data = sm_ctrl_pkg::FAIL_DATA;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_IDLE;
            sweep_req  <= 1'b0;
            lookup_ack <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (accept)
                    begin
                        if (do_disable)
                            state <= S_PS;
                        else if (do_id)
                            state <= S_ID;
                        else
                        begin
                            sweep_req <= 1'b1;
                            state     <= S_SWEEP;
                        end
                    end
                end
                S_PS: state <= S_PE;
                S_PE: state <= S_SS;
                S_SS: state <= S_SE;
                S_SE, S_ID:
                begin
                    sweep_req <= 1'b1;
                    state     <= S_SWEEP;
                end
                S_SWEEP:
                begin
                    if (sweep_ack)
                    begin
                        sweep_req  <= 1'b0;
                        lookup_ack <= 1'b1;
                        state      <= S_HOLD;
                    end
                end
                S_HOLD:
                begin
                    // both handshakes back to zero before the next job
                    if (!lookup_req && !sweep_ack)
                    begin
                        lookup_ack <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (accept)
                begin
                    job_q.clear <= do_disable;
                    job_q.code  <= '0;
                    job_q.data  <= '0;
                    job_q.wb    <= wb_init;
                end
            end
            S_PS: job_q.code.base  <= sm_data;
            S_PE: job_q.code.limit <= sm_data;
            S_SS: job_q.data.base  <= sm_data;
            S_SE: job_q.data.limit <= sm_data;
            S_ID: job_q.wb.data    <= sm_data;
            default: ;
        endcase
    end

endmodule

// File: hw/sm_section_clear.sv
`timescale 1ns/1ps

module sm_section_clear
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sweep_req,
    input  sm_ctrl_pkg::sweep_job_t sweep_job,
    output logic                    sweep_ack,
    output logic                    mb_en,
    output logic              [1:0] mb_wr,
    output sm_ctrl_pkg::word_t      mab,
    output logic                    wb_valid,
    output sm_ctrl_pkg::reg_wb_t    wb
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_CODE,
        S_DATA
    } state_t;

    state_t               state;
    sm_ctrl_pkg::word_t   addr_q;
    sm_ctrl_pkg::word_t   limit_q;
    sm_ctrl_pkg::range_t  data_q;
    sm_ctrl_pkg::reg_wb_t wb_q;
    logic                 accept;
    logic                 done;
    logic                 last;
    logic          [16:0] next_addr;

    assign accept = (state == S_IDLE) && sweep_req && !sweep_ack;

    // at or past the limit, so an empty range writes nothing
    assign done = addr_q >= limit_q;

    // extra bit keeps a range ending at the top of memory from wrapping
    assign next_addr = {1'b0, addr_q} + {1'b0, sm_ctrl_pkg::WORD_BYTES};
    assign last      = next_addr >= {1'b0, limit_q};

    assign mb_en = (state != S_IDLE) && !done;
    assign mb_wr = {2{mb_en}};
    assign mab   = addr_q;
    assign wb    = wb_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= S_IDLE;
            sweep_ack <= 1'b0;
            wb_valid  <= 1'b0;
        end
        else
        begin
            wb_valid <= 1'b0;

            if (accept)
                sweep_ack <= 1'b1;
            else if (!sweep_req)
                sweep_ack <= 1'b0;

            case (state)
                S_IDLE:
                begin
                    if (accept)
                    begin
                        if (sweep_job.clear)
                            state <= S_CODE;
                        else
                            wb_valid <= 1'b1;
                    end
                end
                S_CODE:
                begin
                    if (done || last)
                        state <= S_DATA;
                end
                S_DATA:
                begin
                    // result goes out right after the final zero write
                    if (done || last)
                    begin
                        wb_valid <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (accept)
                begin
                    addr_q  <= sweep_job.code.base;
                    limit_q <= sweep_job.code.limit;
                    data_q  <= sweep_job.data;
                    wb_q    <= sweep_job.wb;
                end
            end
            S_CODE:
            begin
                // switch straight to the data section, no idle cycle
                if (done || last)
                begin
                    addr_q  <= data_q.base;
                    limit_q <= data_q.limit;
                end
                else
                    addr_q <= next_addr[15:0];
            end
            S_DATA:
            begin
                if (!done)
                    addr_q <= next_addr[15:0];
            end
            default: ;
        endcase
    end

endmodule

// File: hw/sm_ctrl.sv
`timescale 1ns/1ps

module sm_ctrl
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_req,
    input  sm_ctrl_pkg::cmd_t    cmd,
    input  logic                 sm_select_valid,
    input  sm_ctrl_pkg::word_t   sm_data,
    output logic                 cmd_ack,
    output sm_ctrl_pkg::word_t   sm_select,
    output sm_ctrl_pkg::sm_req_e sm_req,
    output logic                 mb_en,
    output logic           [1:0] mb_wr,
    output sm_ctrl_pkg::word_t   mab,
    output logic                 wb_valid,
    output sm_ctrl_pkg::reg_wb_t wb
);

    logic                     lookup_req;
    logic                     lookup_ack;
    sm_ctrl_pkg::lookup_job_t lookup_job;
    logic                     sweep_req;
    logic                     sweep_ack;
    sm_ctrl_pkg::sweep_job_t  sweep_job;

    // command latch and module select
    sm_cmd_intake intake_i
    (
        .clk             (clk),
        .reset           (reset),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .sm_select_valid (sm_select_valid),
        .lookup_ack      (lookup_ack),
        .cmd_ack         (cmd_ack),
        .sm_select       (sm_select),
        .lookup_req      (lookup_req),
        .lookup_job      (lookup_job)
    );

    // protection unit queries
    sm_range_lookup lookup_i
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_req (lookup_req),
        .lookup_job (lookup_job),
        .sm_data    (sm_data),
        .sweep_ack  (sweep_ack),
        .lookup_ack (lookup_ack),
        .sm_req     (sm_req),
        .sweep_req  (sweep_req),
        .sweep_job  (sweep_job)
    );

    // memory clear and register write-back
    sm_section_clear clear_i
    (
        .clk       (clk),
        .reset     (reset),
        .sweep_req (sweep_req),
        .sweep_job (sweep_job),
        .sweep_ack (sweep_ack),
        .mb_en     (mb_en),
        .mb_wr     (mb_wr),
        .mab       (mab),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

// File: tests/sm_ctrl_model.sv
`timescale 1ns/1ps

module sm_ctrl_model
(
    input  logic                 clk,
    input  sm_ctrl_pkg::word_t   sm_select,
    input  sm_ctrl_pkg::sm_req_e sm_req,
    input  logic                 mb_en,
    input  logic           [1:0] mb_wr,
    input  sm_ctrl_pkg::word_t   mab,
    output logic                 sm_select_valid,
    output sm_ctrl_pkg::word_t   sm_data
);

    localparam int MODS      = 3;
    localparam int MEM_WORDS = 32768;

    // module k sits at index k, limits are exclusive
    localparam logic [MODS-1:0][15:0] PUB_START = {16'h5000, 16'h3000, 16'h1000};
    localparam logic [MODS-1:0][15:0] PUB_END   = {16'h5006, 16'h3020, 16'h1010};
    localparam logic [MODS-1:0][15:0] SEC_START = {16'h6000, 16'h4000, 16'h2000};
    localparam logic [MODS-1:0][15:0] SEC_END   = {16'h6010, 16'h4000, 16'h2008};
    localparam logic [MODS-1:0][15:0] MOD_ID    = {16'h0033, 16'h0022, 16'h0011};

    sm_ctrl_pkg::word_t mem [0:MEM_WORDS-1];
    int                 sel;

    function automatic logic in_module(input int k, input sm_ctrl_pkg::word_t a);
        return ((a >= PUB_START[k]) && (a < PUB_END[k]))
            || ((a >= SEC_START[k]) && (a < SEC_END[k]));
    endfunction

    function automatic int find_module(input sm_ctrl_pkg::word_t a);
        for (int k = 0; k < MODS; k++)
        begin
            if (in_module(k, a))
                return k;
        end
        return -1;
    endfunction

    always_comb
    begin
        sel             = find_module(sm_select);
        sm_select_valid = (sel >= 0);
        sm_data         = 16'h0000;
        if (sel >= 0)
        begin
            case (sm_req)
                sm_ctrl_pkg::REQ_PUBSTART: sm_data = PUB_START[sel];
                sm_ctrl_pkg::REQ_PUBEND:   sm_data = PUB_END[sel];
                sm_ctrl_pkg::REQ_SECSTART: sm_data = SEC_START[sel];
                sm_ctrl_pkg::REQ_SECEND:   sm_data = SEC_END[sel];
                sm_ctrl_pkg::REQ_ID:       sm_data = MOD_ID[sel];
                default:                   sm_data = 16'h0000;
            endcase
        end
    end

    // nonzero fill, bit 0 always set
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = {i[14:0], 1'b1} ^ 16'h6c00;
    end

    always @(posedge clk)
    begin
        if (mb_en && (mb_wr == 2'b11))
            mem[mab[15:1]] <= 16'h0000;
    end

endmodule

// File: tests/sm_ctrl_tb.sv
`timescale 1ns/1ps

module sm_ctrl_tb;

    localparam int ROWS            = 12;
    // longest model section in words
    localparam int MAX_RANGE_WORDS = 16;
    localparam int LIMIT_CYCLES    = ROWS * (MAX_RANGE_WORDS + 20) + 100;
    localparam int MEM_WORDS       = 32768;

    logic                 clk;
    logic                 reset;
    logic                 cmd_req;
    sm_ctrl_pkg::cmd_t    cmd;
    logic                 sm_select_valid;
    sm_ctrl_pkg::word_t   sm_data;
    logic                 cmd_ack;
    sm_ctrl_pkg::word_t   sm_select;
    sm_ctrl_pkg::sm_req_e sm_req;
    logic                 mb_en;
    logic           [1:0] mb_wr;
    sm_ctrl_pkg::word_t   mab;
    logic                 wb_valid;
    sm_ctrl_pkg::reg_wb_t wb;

    // command table with expected results
    // row_clear holds the disabled module or -1
    sm_ctrl_pkg::cmd_op_e row_op [ROWS];
    sm_ctrl_pkg::word_t   row_pc [ROWS];
    sm_ctrl_pkg::word_t   row_r15 [ROWS];
    sm_ctrl_pkg::word_t   row_prev [ROWS];
    sm_ctrl_pkg::word_t   row_mask [ROWS];
    sm_ctrl_pkg::word_t   row_data [ROWS];
    int                   row_clear [ROWS];

    sm_ctrl_pkg::word_t   mem_start [MEM_WORDS];
    int                   seed    = 84;
    int                   errors  = 0;
    int                   checks  = 0;
    int                   results = 0;

    sm_ctrl sm_ctrl_i
    (
        .clk             (clk),
        .reset           (reset),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .sm_select_valid (sm_select_valid),
        .sm_data         (sm_data),
        .cmd_ack         (cmd_ack),
        .sm_select       (sm_select),
        .sm_req          (sm_req),
        .mb_en           (mb_en),
        .mb_wr           (mb_wr),
        .mab             (mab),
        .wb_valid        (wb_valid),
        .wb              (wb)
    );

    sm_ctrl_model model_i
    (
        .clk             (clk),
        .sm_select       (sm_select),
        .sm_req          (sm_req),
        .mb_en           (mb_en),
        .mb_wr           (mb_wr),
        .mab             (mab),
        .sm_select_valid (sm_select_valid),
        .sm_data         (sm_data)
    );

    task automatic set_row(input int i, input sm_ctrl_pkg::cmd_op_e op,
                           input sm_ctrl_pkg::word_t pc, input sm_ctrl_pkg::word_t r15,
                           input sm_ctrl_pkg::word_t prev, input sm_ctrl_pkg::word_t mask,
                           input sm_ctrl_pkg::word_t data, input int clear_mod);
        row_op[i]    = op;
        row_pc[i]    = pc;
        row_r15[i]   = r15;
        row_prev[i]  = prev;
        row_mask[i]  = mask;
        row_data[i]  = data;
        row_clear[i] = clear_mod;
    endtask

    task automatic fill_table();
        set_row(0, sm_ctrl_pkg::CMD_ID, 16'h0000, 16'h1004, 16'h0000,
                sm_ctrl_pkg::DEST_R15, 16'h0011, -1);
        set_row(1, sm_ctrl_pkg::CMD_ID, 16'h0000, 16'h2006, 16'h0000,
                sm_ctrl_pkg::DEST_R15, 16'h0011, -1);
        set_row(2, sm_ctrl_pkg::CMD_ID, 16'h0000, 16'h7000, 16'h0000,
                sm_ctrl_pkg::DEST_R15, sm_ctrl_pkg::FAIL_DATA, -1);
        set_row(3, sm_ctrl_pkg::CMD_ID_PREV, 16'h3002, 16'h0000, 16'h0abc,
                sm_ctrl_pkg::DEST_R15, 16'h0abc, -1);
        set_row(4, sm_ctrl_pkg::CMD_ID_PREV, 16'h9998, 16'h0000, 16'h1234,
                sm_ctrl_pkg::DEST_R15, 16'h1234, -1);
        set_row(5, sm_ctrl_pkg::CMD_DISABLE, 16'h1002, 16'hbeef, 16'h0000,
                sm_ctrl_pkg::DEST_PC, 16'hbeef, 0);
        set_row(6, sm_ctrl_pkg::CMD_DISABLE, 16'h8000, 16'h1111, 16'h0000,
                sm_ctrl_pkg::DEST_R15, sm_ctrl_pkg::FAIL_DATA, -1);
        set_row(7, sm_ctrl_pkg::CMD_ID, 16'h0000, 16'h3010, 16'h0000,
                sm_ctrl_pkg::DEST_R15, 16'h0022, -1);
        set_row(8, sm_ctrl_pkg::CMD_DISABLE, 16'h6004, 16'h4242, 16'h0000,
                sm_ctrl_pkg::DEST_PC, 16'h4242, 2);
        // module 1 has an empty secret section
        set_row(9, sm_ctrl_pkg::CMD_DISABLE, 16'h3000, 16'h0102, 16'h0000,
                sm_ctrl_pkg::DEST_PC, 16'h0102, 1);
        set_row(10, sm_ctrl_pkg::CMD_ID, 16'h0000, 16'h5004, 16'h0000,
                sm_ctrl_pkg::DEST_R15, 16'h0033, -1);
        set_row(11, sm_ctrl_pkg::CMD_ID_PREV, 16'h5000, 16'h0000, 16'h0c3e,
                sm_ctrl_pkg::DEST_R15, 16'h0c3e, -1);
    endtask

    task automatic check_value(input string what, input sm_ctrl_pkg::word_t got,
                               input sm_ctrl_pkg::word_t expected);
        checks++;
        if (got !== expected)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic send_command(input int i);
        @(posedge clk);
        #1;
        cmd.op      = row_op[i];
        cmd.pc      = row_pc[i];
        cmd.r15     = row_r15[i];
        cmd.prev_id = row_prev[i];
        cmd_req     = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!cmd_ack);
        cmd_req = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (cmd_ack);
    endtask

    // cleared words are zero, all others keep their start value
    task automatic check_memory();
        logic               cleared;
        sm_ctrl_pkg::word_t addr;

        for (int a = 0; a < MEM_WORDS; a++)
        begin
            addr    = sm_ctrl_pkg::word_t'(a * sm_ctrl_pkg::WORD_BYTES);
            cleared = 1'b0;
            for (int r = 0; r < ROWS; r++)
            begin
                if (row_clear[r] >= 0 && model_i.in_module(row_clear[r], addr))
                    cleared = 1'b1;
            end
            check_value($sformatf("memory word %h", addr), model_i.mem[a],
                        cleared ? 16'h0000 : mem_start[a]);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: only %0d of %0d results after %0d cycles",
                 results, ROWS, LIMIT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // results must arrive in table order
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && wb_valid)
            begin
                if (results < ROWS)
                begin
                    check_value($sformatf("row %0d dest_mask", results), wb.dest_mask,
                                row_mask[results]);
                    check_value($sformatf("row %0d data", results), wb.data,
                                row_data[results]);
                end
                else
                begin
                    $display("error at %0t: write-back after the last command", $time);
                    errors++;
                end
                results++;
            end
        end
    end

    initial
    begin
        int gap;

        reset   = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        fill_table();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int a = 0; a < MEM_WORDS; a++)
            mem_start[a] = model_i.mem[a];

        for (int i = 0; i < ROWS; i++)
        begin
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk);
            send_command(i);
        end

        while (results < ROWS)
            @(posedge clk);
        // room for a stray extra write-back
        repeat (5) @(posedge clk);
        check_memory();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: sm_ctrl.f
hw/sm_ctrl_pkg.sv
hw/sm_cmd_intake.sv
hw/sm_range_lookup.sv
hw/sm_section_clear.sv
hw/sm_ctrl.sv
tests/sm_ctrl_model.sv
tests/sm_ctrl_tb.sv
